// ==== Bender.yml ====
package:
  name: vic_loader

sources:
  - files:
      - hdl/vic_load_pkg.sv
      - hdl/load_decode.sv
      - hdl/load_execute.sv
      - hdl/load_result.sv
      - hdl/vic_loader.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_vic_loader.sv

// ==== build.f ====
+incdir+tests
hdl/vic_load_pkg.sv
hdl/load_decode.sv
hdl/load_execute.sv
hdl/load_result.sv
hdl/vic_loader.sv
tests/tb_vic_loader.sv

// ==== hdl/load_decode.sv ====
//////////////////////////////
// Download decode stage, file kind latch
// and byte / end token framing
//////////////////////////////

`timescale 1ns/1ns

module load_decode
	import vic_load_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       download_i,
	input  dl_index_t  index_i,
	input  mem_data_t  file_ext_i,
	input  logic       dl_valid_i,
	input  dl_byte_s   dl_byte_i,
	output logic       dl_ready_o,
	output logic       item_valid_o,
	output load_item_s item_o,
	input  logic       item_ready_i
);

	logic       download_q;
	logic       dl_rise;
	logic       dl_fall;
	load_kind_e kind_q;
	mem_addr_t  start_q;
	load_kind_e kind_cur;
	mem_addr_t  start_cur;
	mem_addr_t  ext_start;
	logic       end_pend_q;
	logic       item_valid_q;
	load_item_s item_q;
	logic       dl_fire;
	logic       load_slot;
	logic       end_load;

	assign dl_rise = download_i & ~download_q;
	assign dl_fall = ~download_i & download_q;

	// CT start address from the last extension character
	always_comb begin
		ext_start = '0;
		if (file_ext_i >= "2" && file_ext_i <= "9")
			ext_start = {file_ext_i[3:0], 12'h000};
		else if (file_ext_i >= "A" && file_ext_i <= "B")
			ext_start = {file_ext_i[3:0] + 4'd9, 12'h000};
	end

	// A byte in the same cycle as the rising edge uses the new kind
	assign kind_cur  = dl_rise ? kind_of_index(index_i) : kind_q;
	assign start_cur = dl_rise ? ext_start : start_q;

	assign load_slot  = ~item_valid_q | item_ready_i;
	assign dl_ready_o = item_ready_i & ~end_pend_q;
	assign dl_fire    = dl_valid_i & dl_ready_o;
	assign end_load   = end_pend_q & load_slot;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q   <= 1'b0;
			kind_q       <= LOAD_NONE;
			start_q      <= '0;
			end_pend_q   <= 1'b0;
			item_valid_q <= 1'b0;
		end else begin
			download_q <= download_i;
			if (dl_rise) begin
				kind_q  <= kind_cur;
				start_q <= start_cur;
			end
			if (item_valid_q && item_ready_i)
				item_valid_q <= 1'b0;
			if (dl_fire || end_load)
				item_valid_q <= 1'b1;
			if (end_load)
				end_pend_q <= 1'b0;
			// End token waits until every byte has been framed
			if (dl_fall)
				end_pend_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_fire)
			item_q <= '{item_kind: ITEM_BYTE, load_kind: kind_cur,
				offset: dl_byte_i.offset, data: dl_byte_i.data, start: start_cur};
		else if (end_load)
			item_q <= '{item_kind: ITEM_END, load_kind: kind_q,
				offset: '0, data: '0, start: start_q};
	end

	assign item_valid_o = item_valid_q;
	assign item_o       = item_q;

endmodule

// ==== hdl/load_execute.sv ====
//////////////////////////////
// Execute stage, running load address, range rules
// and cartridge block flags
//////////////////////////////

`timescale 1ns/1ns

module load_execute
	import vic_load_pkg::*;
#(
	parameter mem_addr_t PRG_LIMIT  = PRG_LIMIT_DEF,
	parameter mem_addr_t CART_LIMIT = CART_LIMIT_DEF
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       item_valid_i,
	input  load_item_s item_i,
	output logic       item_ready_o,
	output logic       wr_valid_o,
	output mem_wr_s    wr_o,
	input  logic       wr_ready_i,
	output logic       patch_start_o,
	output mem_addr_t  patch_addr_o,
	output blk_flags_t cart_blk_o
);

	mem_addr_t  addr_q;
	logic       wr_valid_q;
	mem_wr_s    wr_q;
	logic       patch_start_q;
	mem_addr_t  patch_addr_q;
	blk_flags_t blk_q;

	logic       is_byte;
	logic       is_hdr_lo;
	logic       is_hdr_hi;
	logic       end_prg;
	logic       item_fire;
	logic       hit;
	mem_addr_t  cur_addr;
	mem_addr_t  wr_addr;
	mem_addr_t  next_addr;
	blk_flags_t blk_set;

	assign is_byte   = (item_i.item_kind == ITEM_BYTE);
	assign is_hdr_lo = (item_i.offset == dl_offset_t'(0));
	assign is_hdr_hi = (item_i.offset == dl_offset_t'(1));
	assign end_prg   = ~is_byte & (item_i.load_kind == LOAD_PRG);

	// Stalls while a patch starts, and holds a PRG end until the write register drains
	assign item_ready_o = wr_ready_i & ~patch_start_q & ~(end_prg & wr_valid_q);
	assign item_fire    = item_valid_i & item_ready_o;

	//////////////////////////////
	// Range rules per file kind

	always_comb begin
		hit       = 1'b0;
		cur_addr  = addr_q;
		wr_addr   = addr_q;
		next_addr = addr_q;
		blk_set   = '0;
		if (is_byte) begin
			case (item_i.load_kind)
				LOAD_PRG, LOAD_CRT: begin
					if (is_hdr_lo)
						next_addr = {addr_q[15:8], item_i.data};
					else if (is_hdr_hi)
						next_addr = {item_i.data, addr_q[7:0]};
					else if (item_i.load_kind == LOAD_PRG)
						hit = (addr_q < PRG_LIMIT);
					else
						hit = (addr_q < CART_LIMIT);
				end
				LOAD_CT: begin
					// Headerless, first byte goes to the extension address
					if (is_hdr_lo)
						cur_addr = item_i.start;
					hit = (cur_addr < CART_LIMIT);
				end
				LOAD_ROM: begin
					hit = (item_i.offset >= ROM_WIN_LO) && (item_i.offset < ROM_WIN_HI);
					cur_addr = item_i.offset[15:0] + ROM_OFFSET;
				end
				default: hit = 1'b0;
			endcase
		end
		if (hit) begin
			wr_addr = cur_addr;
			if (item_i.load_kind != LOAD_ROM)
				next_addr = cur_addr + 16'd1;
			if (item_i.load_kind == LOAD_CRT || item_i.load_kind == LOAD_CT) begin
				case (cur_addr[15:13])
					3'b000:  blk_set[0] = 1'b1;
					3'b001:  blk_set[1] = 1'b1;
					3'b010:  blk_set[2] = 1'b1;
					3'b011:  blk_set[3] = 1'b1;
					3'b101:  blk_set[4] = 1'b1;
					default: blk_set = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			addr_q        <= '0;
			wr_valid_q    <= 1'b0;
			patch_start_q <= 1'b0;
			blk_q         <= '0;
		end else begin
			patch_start_q <= 1'b0;
			if (wr_valid_q && wr_ready_i)
				wr_valid_q <= 1'b0;
			if (item_fire) begin
				addr_q <= next_addr;
				blk_q  <= blk_q | blk_set;
				if (hit)
					wr_valid_q <= 1'b1;
				if (end_prg)
					patch_start_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (item_fire && hit)
			wr_q <= '{addr: wr_addr, data: item_i.data};
		if (item_fire && end_prg)
			patch_addr_q <= addr_q;
	end

	assign wr_valid_o    = wr_valid_q;
	assign wr_o          = wr_q;
	assign patch_start_o = patch_start_q;
	assign patch_addr_o  = patch_addr_q;
	assign cart_blk_o    = blk_q;

endmodule

// ==== hdl/load_result.sv ====
//////////////////////////////
// Result stage, memory write register
// and PRG pointer patch sequencer
//////////////////////////////

`timescale 1ns/1ns

module load_result
	import vic_load_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      wr_valid_i,
	input  mem_wr_s   wr_i,
	output logic      wr_ready_o,
	input  logic      patch_start_i,
	input  mem_addr_t patch_addr_i,
	output logic      mem_valid_o,
	output mem_wr_s   mem_wr_o,
	input  logic      mem_ready_i
);

	typedef enum logic {
		ST_IDLE,
		ST_PATCH
	} res_state_e;

	res_state_e state_q;
	logic [2:0] idx_q;
	mem_addr_t  end_addr_q;
	logic       mem_valid_q;
	mem_wr_s    mem_q;
	logic       slot_free;
	logic       wr_fire;
	logic       patch_load;
	mem_data_t  patch_data;

	// Output register is free when empty or being taken this cycle
	assign slot_free  = ~mem_valid_q | mem_ready_i;
	assign wr_ready_o = (state_q == ST_IDLE) & slot_free;
	assign wr_fire    = wr_valid_i & wr_ready_o;
	assign patch_load = (state_q == ST_PATCH) & slot_free;

	// Even positions take the low byte, odd ones the high byte
	assign patch_data = idx_q[0] ? end_addr_q[15:8] : end_addr_q[7:0];

	//////////////////////////////
	// Patch FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q     <= ST_IDLE;
			idx_q       <= '0;
			mem_valid_q <= 1'b0;
		end else begin
			if (mem_valid_q && mem_ready_i)
				mem_valid_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (wr_fire)
						mem_valid_q <= 1'b1;
					if (patch_start_i) begin
						state_q <= ST_PATCH;
						idx_q   <= '0;
					end
				end
				ST_PATCH: begin
					if (patch_load) begin
						mem_valid_q <= 1'b1;
						idx_q       <= idx_q + 3'd1;
						if (idx_q == 3'd7)
							state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state_q == ST_IDLE && patch_start_i)
			end_addr_q <= patch_addr_i;
		if (wr_fire)
			mem_q <= wr_i;
		else if (patch_load)
			mem_q <= '{addr: PTR_ADDR[idx_q], data: patch_data};
	end

	assign mem_valid_o = mem_valid_q;
	assign mem_wr_o    = mem_q;

endmodule

// ==== hdl/vic_load_pkg.sv ====
//////////////////////////////
// Loader types, file kinds, struct formats
// and the fixed address constants
//////////////////////////////

package vic_load_pkg;

	//////////////////////////////
	// Basic widths

	typedef logic [15:0] mem_addr_t;
	typedef logic [7:0]  mem_data_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [24:0] dl_offset_t;

	// Bits 0-3 are blocks 0x0000-0x6000, bit 4 is 0xA000
	typedef logic [4:0] blk_flags_t;

	typedef enum logic [2:0] {
		LOAD_NONE,
		LOAD_PRG,
		LOAD_CRT,
		LOAD_CT,
		LOAD_ROM
	} load_kind_e;

	typedef enum logic {
		ITEM_BYTE,
		ITEM_END
	} item_kind_e;

	//////////////////////////////
	// Stream formats

	typedef struct packed {
		dl_offset_t offset;
		mem_data_t  data;
	} dl_byte_s;

	typedef struct packed {
		item_kind_e item_kind;
		load_kind_e load_kind;
		dl_offset_t offset;
		mem_data_t  data;
		mem_addr_t  start;
	} load_item_s;

	typedef struct packed {
		mem_addr_t addr;
		mem_data_t data;
	} mem_wr_s;

	//////////////////////////////
	// Address constants

	// BASIC pointers patched with the PRG end address, low byte first
	localparam mem_addr_t PTR_ADDR [0:7] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h00AE, 16'h00AF
	};

	localparam dl_offset_t ROM_WIN_LO = 25'h0004000;
	localparam dl_offset_t ROM_WIN_HI = 25'h0008000;
	localparam mem_addr_t  ROM_OFFSET = 16'h8000;

	localparam mem_addr_t PRG_LIMIT_DEF  = 16'hA000;
	localparam mem_addr_t CART_LIMIT_DEF = 16'hC000;

	// Host file index to load kind
	function automatic load_kind_e kind_of_index(input dl_index_t index);
		case (index)
			8'h01:   return LOAD_PRG;
			8'h41:   return LOAD_CRT;
			8'h81:   return LOAD_CT;
			8'h06:   return LOAD_ROM;
			default: return LOAD_NONE;
		endcase
	endfunction

endpackage

// ==== hdl/vic_loader.sv ====
//////////////////////////////
// Loader top, decode / execute / result chain
//////////////////////////////

`timescale 1ns/1ns

module vic_loader
	import vic_load_pkg::*;
#(
	parameter mem_addr_t PRG_LIMIT  = PRG_LIMIT_DEF,
	parameter mem_addr_t CART_LIMIT = CART_LIMIT_DEF
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       download_i,
	input  dl_index_t  index_i,
	input  mem_data_t  file_ext_i,
	input  logic       dl_valid_i,
	input  dl_byte_s   dl_byte_i,
	output logic       dl_ready_o,
	output logic       mem_valid_o,
	output mem_wr_s    mem_wr_o,
	input  logic       mem_ready_i,
	output blk_flags_t cart_blk_o
);

	logic       item_valid;
	load_item_s item;
	logic       item_ready;
	logic       wr_valid;
	mem_wr_s    wr;
	logic       wr_ready;
	logic       patch_start;
	mem_addr_t  patch_addr;

	load_decode u_decode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download_i   (download_i),
		.index_i      (index_i),
		.file_ext_i   (file_ext_i),
		.dl_valid_i   (dl_valid_i),
		.dl_byte_i    (dl_byte_i),
		.dl_ready_o   (dl_ready_o),
		.item_valid_o (item_valid),
		.item_o       (item),
		.item_ready_i (item_ready)
	);

	load_execute #(
		.PRG_LIMIT  (PRG_LIMIT),
		.CART_LIMIT (CART_LIMIT)
	) u_execute (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.item_valid_i  (item_valid),
		.item_i        (item),
		.item_ready_o  (item_ready),
		.wr_valid_o    (wr_valid),
		.wr_o          (wr),
		.wr_ready_i    (wr_ready),
		.patch_start_o (patch_start),
		.patch_addr_o  (patch_addr),
		.cart_blk_o    (cart_blk_o)
	);

	load_result u_result (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.wr_valid_i    (wr_valid),
		.wr_i          (wr),
		.wr_ready_o    (wr_ready),
		.patch_start_i (patch_start),
		.patch_addr_i  (patch_addr),
		.mem_valid_o   (mem_valid_o),
		.mem_wr_o      (mem_wr_o),
		.mem_ready_i   (mem_ready_i)
	);

endmodule

// ==== tests/tb_load_model.svh ====
//////////////////////////////
// Reference model, expected writes and block flags
//////////////////////////////

`ifndef TB_LOAD_MODEL_SVH
`define TB_LOAD_MODEL_SVH

// BASIC pointers patched after a PRG, low byte first
localparam mem_addr_t BASIC_PTRS [0:7] = '{
	16'h002D, 16'h002E, 16'h002F, 16'h0030,
	16'h0031, 16'h0032, 16'h00AE, 16'h00AF
};

// CT start address from the last character of the extension
function automatic mem_addr_t start_of_ext(input mem_data_t ext);
	if (ext >= "2" && ext <= "9")
		return mem_addr_t'(ext - "0") << 12;
	else if (ext == "A" || ext == "B")
		return mem_addr_t'(ext - "A" + 8'd10) << 12;
	return '0;
endfunction

task automatic expect_write(input mem_addr_t a, input mem_data_t d);
	exp_q.push_back('{addr: a, data: d});
endtask

// Four 8 KB blocks below 0x8000, one at 0xA000
task automatic mark_block(input mem_addr_t a);
	if (a < 16'h8000)
		exp_blk[a[14:13]] = 1'b1;
	else if (a >= 16'hA000 && a < 16'hC000)
		exp_blk[4] = 1'b1;
endtask

task automatic model_prg(input mem_addr_t limit);
	mem_addr_t addr;
	addr = '0;
	foreach (file_q[i]) begin
		if (file_q[i].offset == 0)
			addr[7:0] = file_q[i].data;
		else if (file_q[i].offset == 1)
			addr[15:8] = file_q[i].data;
		else if (addr < limit) begin
			expect_write(addr, file_q[i].data);
			addr = addr + 16'd1;
		end
	end
	for (int p = 0; p < 8; p++)
		expect_write(BASIC_PTRS[p], (p % 2 == 1) ? addr[15:8] : addr[7:0]);
endtask

task automatic model_cart(input logic headerless, input mem_addr_t start,
		input mem_addr_t limit);
	mem_addr_t addr;
	addr = start;
	foreach (file_q[i]) begin
		if (!headerless && file_q[i].offset == 0)
			addr[7:0] = file_q[i].data;
		else if (!headerless && file_q[i].offset == 1)
			addr[15:8] = file_q[i].data;
		else if (addr < limit) begin
			expect_write(addr, file_q[i].data);
			mark_block(addr);
			addr = addr + 16'd1;
		end
	end
endtask

// Kernal window 0x4000-0x7FFF lands at offset + 0x8000
task automatic model_rom();
	foreach (file_q[i])
		if (file_q[i].offset >= 25'h4000 && file_q[i].offset < 25'h8000)
			expect_write(mem_addr_t'((file_q[i].offset + 25'h8000) % 25'h10000),
				file_q[i].data);
endtask

`endif

// ==== tests/tb_vic_loader.sv ====
//////////////////////////////
// Loader testbench, stimulus, write monitor and checks
//////////////////////////////

`timescale 1ns/1ns

module tb_vic_loader
	import vic_load_pkg::*;
();

	localparam mem_addr_t PRG_TOP  = 16'hA000;
	localparam mem_addr_t CART_TOP = 16'hC000;
	localparam int        WAIT_MAX = 2000;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        download_i;
	dl_index_t   index_i;
	mem_data_t   file_ext_i;
	logic        dl_valid_i;
	dl_byte_s    dl_byte_i;
	logic        dl_ready_o;
	logic        mem_valid_o;
	mem_wr_s     mem_wr_o;
	logic        mem_ready_i;
	blk_flags_t  cart_blk_o;

	dl_byte_s    file_q[$];
	mem_wr_s     exp_q[$];
	mem_wr_s     exp_wr;
	blk_flags_t  exp_blk;
	logic        bp_pat [0:255];
	logic        bp_en;
	int          errors;
	int          stall_cnt;
	int          tests_ok;
	int          tests_bad;

	`include "tb_load_model.svh"

	vic_loader #(
		.PRG_LIMIT  (PRG_TOP),
		.CART_LIMIT (CART_TOP)
	) u_vic_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download_i  (download_i),
		.index_i     (index_i),
		.file_ext_i  (file_ext_i),
		.dl_valid_i  (dl_valid_i),
		.dl_byte_i   (dl_byte_i),
		.dl_ready_o  (dl_ready_o),
		.mem_valid_o (mem_valid_o),
		.mem_wr_o    (mem_wr_o),
		.mem_ready_i (mem_ready_i),
		.cart_blk_o  (cart_blk_o)
	);

	always #50 clk_sys = ~clk_sys;

	// Memory side ready with gaps from the pattern while back-pressure is on
	initial begin
		int cyc;
		cyc = 0;
		mem_ready_i = 1'b1;
		forever begin
			@(posedge clk_sys);
			#10;
			cyc = cyc + 1;
			mem_ready_i = bp_en ? bp_pat[cyc % 256] : 1'b1;
		end
	end

	//////////////////////////////
	// Write monitor

	// Sampled mid-cycle where valid, ready and data are stable
	always @(negedge clk_sys) begin
		if (!reset && mem_valid_o && mem_ready_i) begin
			assert (exp_q.size() != 0) else begin
				$display("Unexpected memory write to %h at time %0t", mem_wr_o.addr, $time);
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_wr = exp_q.pop_front();
				assert (mem_wr_o.addr == exp_wr.addr && mem_wr_o.data == exp_wr.data)
				else begin
					$display("[FAIL] %0t: write %h=%h, expected %h=%h", $time,
						mem_wr_o.addr, mem_wr_o.data, exp_wr.addr, exp_wr.data);
					errors++;
				end
			end
		end
	end

	//////////////////////////////
	// Stimulus tasks

	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) @(posedge clk_sys);
		#10;
		reset = 1'b0;
	endtask

	task automatic build_file(input mem_addr_t hdr, input int n, input logic with_hdr);
		int base;
		file_q.delete();
		base = 0;
		if (with_hdr) begin
			file_q.push_back('{offset: 25'd0, data: hdr[7:0]});
			file_q.push_back('{offset: 25'd1, data: hdr[15:8]});
			base = 2;
		end
		for (int i = 0; i < n; i++)
			file_q.push_back('{offset: dl_offset_t'(base + i), data: mem_data_t'($urandom)});
	endtask

	// Short runs around both window edges and one far above it
	task automatic build_rom();
		dl_offset_t win [0:2];
		win = '{25'h3FF8, 25'h7FF8, 25'h13FFC};
		file_q.delete();
		foreach (win[w])
			for (int i = 0; i < 16; i++)
				file_q.push_back('{offset: win[w] + dl_offset_t'(i), data: mem_data_t'($urandom)});
	endtask

	task automatic send_byte(input dl_byte_s b);
		int   waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		dl_valid_i = 1'b1;
		dl_byte_i = b;
		while (!taken && waited < WAIT_MAX) begin
			@(negedge clk_sys);
			if (dl_ready_o)
				taken = 1'b1;
			else
				stall_cnt++;
			@(posedge clk_sys);
			#10;
			waited++;
		end
		dl_valid_i = 1'b0;
		if (!taken) begin
			$display("Timeout: byte at offset %h was never accepted", b.offset);
			errors++;
		end
	endtask

	task automatic run_load(input dl_index_t idx, input mem_data_t ext);
		int waited;
		index_i = idx;
		file_ext_i = ext;
		download_i = 1'b1;
		@(posedge clk_sys);
		#10;
		foreach (file_q[i])
			send_byte(file_q[i]);
		download_i = 1'b0;
		waited = 0;
		do begin
			@(posedge clk_sys);
			#30;
			waited++;
		end while (!(exp_q.size() == 0 && dl_ready_o) && waited < WAIT_MAX);
		if (exp_q.size() != 0 || !dl_ready_o) begin
			$display("Timeout: load did not finish, %0d writes still missing", exp_q.size());
			errors++;
			exp_q.delete();
		end
		// Quiet window in which an extra write is caught by the monitor
		repeat (8) @(posedge clk_sys);
		#10;
	endtask

	task automatic check_flags();
		@(negedge clk_sys);
		assert (cart_blk_o == exp_blk) else begin
			$display("[FAIL] %0t: cart_blk_o %b, expected %b", $time, cart_blk_o, exp_blk);
			errors++;
		end
		@(posedge clk_sys);
		#10;
	endtask

	task automatic finish_test(input string name, input int err0);
		if (errors == err0) begin
			tests_ok++;
			$display("test %-26s ok", name);
		end else begin
			tests_bad++;
			$display("test %-26s %0d error(s)", name, errors - err0);
		end
	endtask

	//////////////////////////////
	// Test sequence

	initial begin
		int err0;
		int stall0;
		reset = 1'b1;
		download_i = 1'b0;
		index_i = '0;
		file_ext_i = '0;
		dl_valid_i = 1'b0;
		dl_byte_i = '0;
		bp_en = 1'b0;
		errors = 0;
		stall_cnt = 0;
		tests_ok = 0;
		tests_bad = 0;
		exp_blk = '0;
		void'($urandom(96));
		for (int i = 0; i < 256; i++)
			bp_pat[i] = ($urandom % 3) != 0;

		err0 = errors;
		apply_reset();
		@(negedge clk_sys);
		assert (!mem_valid_o && dl_ready_o) else begin
			$display("[FAIL] %0t: after reset valid %b ready %b", $time, mem_valid_o, dl_ready_o);
			errors++;
		end
		@(posedge clk_sys);
		#10;
		check_flags();
		finish_test("state after reset", err0);

		err0 = errors;
		build_file(16'h1001, 20, 1'b1);
		model_prg(PRG_TOP);
		run_load(8'h01, "P");
		finish_test("prg at 1001 with patch", err0);

		err0 = errors;
		build_file(16'h9FF8, 16, 1'b1);
		model_prg(PRG_TOP);
		run_load(8'h01, "P");
		finish_test("prg cut at a000", err0);

		err0 = errors;
		build_rom();
		model_rom();
		run_load(8'h06, "M");
		finish_test("kernal rom window", err0);

		err0 = errors;
		build_file(16'hA000, 12, 1'b1);
		model_cart(1'b0, '0, CART_TOP);
		run_load(8'h41, "T");
		check_flags();
		finish_test("crt at a000", err0);

		err0 = errors;
		build_file('0, 10, 1'b0);
		model_cart(1'b1, start_of_ext("2"), CART_TOP);
		run_load(8'h81, "2");
		check_flags();
		finish_test("ct from extension 2", err0);

		err0 = errors;
		build_file(16'hBFFC, 8, 1'b1);
		model_cart(1'b0, '0, CART_TOP);
		run_load(8'h41, "T");
		check_flags();
		finish_test("crt cut at c000", err0);

		// Block flags clear only on reset
		err0 = errors;
		apply_reset();
		exp_blk = '0;
		check_flags();
		finish_test("reset clears flags", err0);

		err0 = errors;
		bp_en = 1'b1;
		build_file(16'h0801, 40, 1'b1);
		model_prg(PRG_TOP);
		run_load(8'h01, "P");
		bp_en = 1'b0;
		finish_test("prg with back-pressure", err0);

		err0 = errors;
		stall0 = stall_cnt;
		build_file(16'h1234, 12, 1'b1);
		run_load(8'h02, "P");
		assert (stall_cnt == stall0) else begin
			$display("[FAIL] %0t: dl_ready_o low %0d times for unknown index", $time,
				stall_cnt - stall0);
			errors++;
		end
		finish_test("unknown index 02", err0);

		$display("tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
